// File: common/mm_pkg.sv
`default_nettype none

package mm_pkg;

    // ----------------------------------------
    // widths
    // ----------------------------------------
    localparam int RAM_ADDR_WIDTH    = 16;
    // debug window size as a power of two, placed at the top of the RAM
    localparam int DBG_ADDR_WIDTH    = 14;
    localparam int INSTR_RDATA_WIDTH = 128;
    localparam int IRQ_WIDTH         = 32;

    // ----------------------------------------
    // pseudo peripheral address map
    // ----------------------------------------
    localparam logic [31:0] ADDR_TEST_STATUS = 32'h2000_0000;
    localparam logic [31:0] ADDR_EXIT        = 32'h2000_0004;
    localparam logic [31:0] ADDR_TIMER_MASK  = 32'h1500_0000;
    localparam logic [31:0] ADDR_TIMER_COUNT = 32'h1500_0004;
    localparam logic [31:0] ADDR_DEBUG_CTRL  = 32'h1500_0008;

    // test status codes
    localparam logic [31:0] TEST_PASS_CODE = 32'd123456789;
    localparam logic [31:0] TEST_FAIL_CODE = 32'd1;

    // debug control word fields, delay field sits at bit 0
    localparam int DBG_VALUE_BIT = 31;
    localparam int DBG_PULSE_BIT = 30;
    localparam int DBG_DUR_LSB   = 16;

    // ----------------------------------------
    // types
    // ----------------------------------------
    typedef logic [31:0]                   word_t;
    typedef logic [RAM_ADDR_WIDTH-1:0]     ram_addr_t;
    typedef logic [INSTR_RDATA_WIDTH-1:0]  instr_line_t;
    typedef logic [3:0]                    be_t;
    typedef logic [IRQ_WIDTH-1:0]          irq_vec_t;
    typedef logic [$clog2(IRQ_WIDTH)-1:0]  irq_id_t;
    typedef logic [14:0]                   dbg_delay_t;
    typedef logic [12:0]                   dbg_dur_t;

    typedef enum logic [1:0] {
        DBG_IDLE,
        DBG_DELAY,
        DBG_HOLD
    } dbg_state_e;

endpackage

`default_nettype wire

// File: common/ram_port_if.sv
`timescale 1ns/100ps
`default_nettype none

// data side of the RAM, request and write payload in, read word out
interface ram_port_if
    import mm_pkg::*;
();

    logic      req;
    ram_addr_t addr;
    logic      we;
    be_t       be;
    word_t     wdata;
    word_t     rdata;

    modport master (
        output req, addr, we, be, wdata,
        input  rdata
    );

    modport slave (
        input  req, addr, we, be, wdata,
        output rdata
    );

endinterface

`default_nettype wire

// File: common/periph_wr_if.sv
`timescale 1ns/100ps
`default_nettype none

// single-cycle write strobes to the timer and debug registers
interface periph_wr_if
    import mm_pkg::*;
();

    word_t wdata;
    logic  timer_mask_we;
    logic  timer_count_we;
    logic  debug_we;

    modport master (output wdata, timer_mask_we, timer_count_we, debug_we);

    modport timer (input wdata, timer_mask_we, timer_count_we);

    modport debug (input wdata, debug_we);

endinterface

`default_nettype wire

// File: rtl/mem_addr_map.sv
`timescale 1ns/100ps
`default_nettype none

module mem_addr_map
    import mm_pkg::*;
(
    input  wire word_t instr_addr_i,
    input  wire word_t data_addr_i,
    input  wire word_t dm_halt_addr_i,
    output ram_addr_t  instr_ram_addr_o,
    output ram_addr_t  data_ram_addr_o,
    output logic       data_in_ram_o
);

    logic instr_in_dbg;
    logic data_in_dbg;

    // true when addr lies in [halt, halt + debug window)
    function automatic logic in_dbg_window(word_t addr, word_t halt);
        word_t offset;
        offset = addr - halt;
        return (addr >= halt) && (offset < word_t'(2 ** DBG_ADDR_WIDTH));
    endfunction

    // debug window lands at the top of the RAM, sum wraps at RAM size
    function automatic ram_addr_t remap(word_t addr, word_t halt, logic in_dbg);
        word_t offset;
        offset = addr - halt;
        if (in_dbg) begin
            return ram_addr_t'(offset)
                + ram_addr_t'(2 ** RAM_ADDR_WIDTH - 2 ** DBG_ADDR_WIDTH);
        end
        return ram_addr_t'(addr);
    endfunction

    always_comb begin
        instr_in_dbg     = in_dbg_window(instr_addr_i, dm_halt_addr_i);
        data_in_dbg      = in_dbg_window(data_addr_i, dm_halt_addr_i);
        instr_ram_addr_o = remap(instr_addr_i, dm_halt_addr_i, instr_in_dbg);
        data_ram_addr_o  = remap(data_addr_i, dm_halt_addr_i, data_in_dbg);
        data_in_ram_o    = data_in_dbg
                        || (data_addr_i < word_t'(2 ** RAM_ADDR_WIDTH));
    end

endmodule

`default_nettype wire

// File: rtl/data_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module data_decoder
    import mm_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_ni,

    input  wire logic      data_req_i,
    input  wire word_t     data_addr_i,
    input  wire logic      data_we_i,
    input  wire be_t       data_be_i,
    input  wire word_t     data_wdata_i,
    input  wire ram_addr_t data_ram_addr_i,
    input  wire logic      data_in_ram_i,

    output logic           data_gnt_o,
    output word_t          data_rdata_o,
    output logic           data_rvalid_o,

    output logic           tests_passed_o,
    output logic           tests_failed_o,
    output logic           exit_valid_o,
    output word_t          exit_value_o,

    ram_port_if.master     ram_o,
    periph_wr_if.master    periph_o
);

    logic  periph_wr;
    logic  ram_rd_q;
    logic  rvalid_q;

    assign data_gnt_o = data_req_i;

    // ----------------------------------------
    // request routing
    // ----------------------------------------
    always_comb begin
        ram_o.req   = data_req_i && data_in_ram_i;
        ram_o.addr  = data_ram_addr_i;
        ram_o.we    = data_we_i;
        ram_o.be    = data_be_i;
        ram_o.wdata = data_wdata_i;

        // RAM takes priority, peripherals only see writes outside it
        periph_wr = data_req_i && data_we_i && !data_in_ram_i;

        periph_o.wdata          = data_wdata_i;
        periph_o.timer_mask_we  = periph_wr && (data_addr_i == ADDR_TIMER_MASK);
        periph_o.timer_count_we = periph_wr && (data_addr_i == ADDR_TIMER_COUNT);
        periph_o.debug_we       = periph_wr && (data_addr_i == ADDR_DEBUG_CTRL);
    end

    // ----------------------------------------
    // test status and exit
    // ----------------------------------------
    always_comb begin
        tests_passed_o = 1'b0;
        tests_failed_o = 1'b0;
        exit_valid_o   = 1'b0;
        exit_value_o   = '0;

        if (periph_wr && (data_addr_i == ADDR_TEST_STATUS)) begin
            tests_passed_o = (data_wdata_i == TEST_PASS_CODE);
            tests_failed_o = (data_wdata_i == TEST_FAIL_CODE);
        end

        if (periph_wr && (data_addr_i == ADDR_EXIT)) begin
            exit_valid_o = 1'b1;
            exit_value_o = data_wdata_i;
        end
    end

    // every request gets its rvalid one cycle later, writes included
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            ram_rd_q <= 1'b0;
        end else begin
            rvalid_q <= data_req_i;
            ram_rd_q <= data_req_i && !data_we_i && data_in_ram_i;
        end
    end

    assign data_rvalid_o = rvalid_q;

    // reads that missed the RAM return zero
    assign data_rdata_o = ram_rd_q ? ram_o.rdata : '0;

endmodule

`default_nettype wire

// File: ram/dp_ram.sv
`timescale 1ns/100ps
`default_nettype none

module dp_ram
    import mm_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_ni,

    input  wire logic      instr_req_i,
    input  wire ram_addr_t instr_addr_i,
    output instr_line_t    instr_rdata_o,
    output logic           instr_rvalid_o,

    ram_port_if.slave      data_port
);

    logic [7:0] mem [2 ** RAM_ADDR_WIDTH];

    ram_addr_t line_base;
    ram_addr_t word_base;

    // fetch reads the whole aligned line, data port works on aligned words
    assign line_base = instr_addr_i & ~ram_addr_t'(INSTR_RDATA_WIDTH / 8 - 1);
    assign word_base = data_port.addr & ~ram_addr_t'(3);

    // ----------------------------------------
    // instruction port
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (instr_req_i) begin
            for (int k = 0; k < INSTR_RDATA_WIDTH / 8; k++) begin
                instr_rdata_o[8*k +: 8] <= mem[line_base + ram_addr_t'(k)];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            instr_rvalid_o <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
        end
    end

    // ----------------------------------------
    // data port
    // ----------------------------------------
    always_ff @(posedge clk_i) begin
        if (data_port.req) begin
            if (data_port.we) begin
                for (int k = 0; k < 4; k++) begin
                    if (data_port.be[k]) begin
                        mem[word_base + ram_addr_t'(k)] <= data_port.wdata[8*k +: 8];
                    end
                end
            end else begin
                for (int k = 0; k < 4; k++) begin
                    data_port.rdata[8*k +: 8] <= mem[word_base + ram_addr_t'(k)];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/irq_timer.sv
`timescale 1ns/100ps
`default_nettype none

module irq_timer
    import mm_pkg::*;
(
    input  wire logic    clk_i,
    input  wire logic    rst_ni,
    input  wire logic    irq_ack_i,
    input  wire irq_id_t irq_id_i,
    output irq_vec_t     irq_o,

    periph_wr_if.timer   wr_i
);

    irq_vec_t mask_q;
    word_t    cnt_q;
    irq_vec_t irq_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_q  <= '0;
        end else begin
            if (wr_i.timer_mask_we) begin
                mask_q <= irq_vec_t'(wr_i.wdata);
            end

            // a fresh count wins over the running countdown
            if (wr_i.timer_count_we) begin
                cnt_q <= wr_i.wdata;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - 1'b1;
            end

            // expiry sets the whole mask, ack clears one bit
            if (cnt_q == word_t'(1)) begin
                irq_q <= mask_q;
            end else if (irq_ack_i) begin
                irq_q[irq_id_i] <= 1'b0;
            end
        end
    end

    assign irq_o = irq_q;

endmodule

`default_nettype wire

// File: rtl/debug_req_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module debug_req_ctrl
    import mm_pkg::*;
(
    input  wire logic  clk_i,
    input  wire logic  rst_ni,
    output logic       debug_req_o,

    periph_wr_if.debug wr_i
);

    dbg_state_e state_q;
    dbg_delay_t delay_cnt_q;
    dbg_dur_t   dur_cnt_q;
    logic       value_q;
    logic       pulse_q;

    // control word fields
    logic       wr_value;
    logic       wr_pulse;
    dbg_delay_t wr_delay;
    dbg_dur_t   wr_dur;

    assign wr_value = wr_i.wdata[DBG_VALUE_BIT];
    assign wr_pulse = wr_i.wdata[DBG_PULSE_BIT];
    assign wr_delay = wr_i.wdata[$bits(dbg_delay_t)-1:0];
    assign wr_dur   = wr_i.wdata[DBG_DUR_LSB +: $bits(dbg_dur_t)];

    // value and mode captured with the request
    always_ff @(posedge clk_i) begin
        if (wr_i.debug_we && (state_q == DBG_IDLE)) begin
            value_q <= wr_value;
            pulse_q <= wr_pulse;
        end
    end

    // ----------------------------------------
    // request sequencing
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q     <= DBG_IDLE;
            delay_cnt_q <= '0;
            dur_cnt_q   <= '0;
            debug_req_o <= 1'b0;
        end else begin
            case (state_q)
                DBG_IDLE: begin
                    // zero delay or duration behaves as one cycle
                    if (wr_i.debug_we) begin
                        delay_cnt_q <= (wr_delay == '0) ? dbg_delay_t'(1) : wr_delay;
                        dur_cnt_q   <= (wr_dur == '0) ? dbg_dur_t'(1) : wr_dur;
                        state_q     <= DBG_DELAY;
                    end
                end
                DBG_DELAY: begin
                    delay_cnt_q <= delay_cnt_q - 1'b1;
                    if (delay_cnt_q == dbg_delay_t'(1)) begin
                        debug_req_o <= value_q;
                        state_q     <= pulse_q ? DBG_HOLD : DBG_IDLE;
                    end
                end
                DBG_HOLD: begin
                    dur_cnt_q <= dur_cnt_q - 1'b1;
                    if (dur_cnt_q == dbg_dur_t'(1)) begin
                        debug_req_o <= !value_q;
                        state_q     <= DBG_IDLE;
                    end
                end
                default: begin
                    state_q <= DBG_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/mm_ram.sv
`timescale 1ns/100ps
`default_nettype none

module mm_ram
    import mm_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_ni,
    input  wire word_t       dm_halt_addr_i,

    input  wire logic        instr_req_i,
    input  wire word_t       instr_addr_i,
    output instr_line_t      instr_rdata_o,
    output logic             instr_rvalid_o,
    output logic             instr_gnt_o,

    input  wire logic        data_req_i,
    input  wire word_t       data_addr_i,
    input  wire logic        data_we_i,
    input  wire be_t         data_be_i,
    input  wire word_t       data_wdata_i,
    output word_t            data_rdata_o,
    output logic             data_rvalid_o,
    output logic             data_gnt_o,

    input  wire irq_id_t     irq_id_i,
    input  wire logic        irq_ack_i,
    output irq_vec_t         irq_o,

    output logic             debug_req_o,

    output logic             tests_passed_o,
    output logic             tests_failed_o,
    output logic             exit_valid_o,
    output word_t            exit_value_o
);

    ram_addr_t instr_ram_addr;
    ram_addr_t data_ram_addr;
    logic      data_in_ram;

    ram_port_if  ram_port ();
    periph_wr_if periph_wr ();

    // no stalls on the fetch side, grant follows request
    assign instr_gnt_o = instr_req_i;

    mem_addr_map addr_map0 (
        .instr_addr_i     (instr_addr_i),
        .data_addr_i      (data_addr_i),
        .dm_halt_addr_i   (dm_halt_addr_i),
        .instr_ram_addr_o (instr_ram_addr),
        .data_ram_addr_o  (data_ram_addr),
        .data_in_ram_o    (data_in_ram)
    );

    data_decoder decoder0 (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .data_req_i      (data_req_i),
        .data_addr_i     (data_addr_i),
        .data_we_i       (data_we_i),
        .data_be_i       (data_be_i),
        .data_wdata_i    (data_wdata_i),
        .data_ram_addr_i (data_ram_addr),
        .data_in_ram_i   (data_in_ram),
        .data_gnt_o      (data_gnt_o),
        .data_rdata_o    (data_rdata_o),
        .data_rvalid_o   (data_rvalid_o),
        .tests_passed_o  (tests_passed_o),
        .tests_failed_o  (tests_failed_o),
        .exit_valid_o    (exit_valid_o),
        .exit_value_o    (exit_value_o),
        .ram_o           (ram_port.master),
        .periph_o        (periph_wr.master)
    );

    dp_ram ram0 (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_ram_addr),
        .instr_rdata_o  (instr_rdata_o),
        .instr_rvalid_o (instr_rvalid_o),
        .data_port      (ram_port.slave)
    );

    irq_timer timer0 (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .irq_ack_i (irq_ack_i),
        .irq_id_i  (irq_id_i),
        .irq_o     (irq_o),
        .wr_i      (periph_wr.timer)
    );

    debug_req_ctrl debug0 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .debug_req_o (debug_req_o),
        .wr_i        (periph_wr.debug)
    );

endmodule

`default_nettype wire

// File: dv/mm_ram_properties.sv
`timescale 1ns/100ps
`default_nettype none

module mm_ram_properties
    import mm_pkg::*;
(
    input wire logic     clk_i,
    input wire logic     rst_ni,
    input wire logic     instr_req_i,
    input wire logic     instr_gnt_o,
    input wire logic     instr_rvalid_o,
    input wire logic     data_req_i,
    input wire logic     data_we_i,
    input wire logic     data_gnt_o,
    input wire logic     data_rvalid_o,
    input wire irq_vec_t irq_o,
    input wire logic     debug_req_o,
    input wire logic     tests_passed_o,
    input wire logic     tests_failed_o,
    input wire logic     exit_valid_o
);

    int unsigned fail_cnt = 0;

    logic status_any;

    assign status_any = tests_passed_o || tests_failed_o || exit_valid_o;

    // ----------------------------------------
    // handshake
    // ----------------------------------------
    gnt_equals_req: assert property (@(posedge clk_i)
        (instr_gnt_o == instr_req_i) && (data_gnt_o == data_req_i))
    else begin
        fail_cnt++;
        $error("grant differs from request");
    end

    instr_rvalid_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        instr_rvalid_o == $past(instr_req_i))
    else begin
        fail_cnt++;
        $error("instr_rvalid_o does not follow instr_req_i by one cycle");
    end

    data_rvalid_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
        data_rvalid_o == $past(data_req_i))
    else begin
        fail_cnt++;
        $error("data_rvalid_o does not follow data_req_i by one cycle");
    end

    // ----------------------------------------
    // reset and status
    // ----------------------------------------
    outputs_low_in_reset: assert property (@(posedge clk_i)
        !rst_ni |-> (!instr_rvalid_o && !data_rvalid_o && (irq_o == '0)
                     && !debug_req_o && !status_any))
    else begin
        fail_cnt++;
        $error("control output high during reset");
    end

    // status outputs are combinational on the write itself
    status_only_on_write: assert property (@(posedge clk_i)
        status_any |-> (data_req_i && data_we_i))
    else begin
        fail_cnt++;
        $error("status output high without a data write");
    end

endmodule

`default_nettype wire

// File: dv/tb_mm_ram.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mm_ram
    import mm_pkg::*;
();

    localparam int    CLK_PERIOD     = 20;
    localparam int    DRIVE_DELAY    = 2;
    localparam int    RESET_CYCLES   = 3;
    // limit far above the few hundred cycles the tests take
    localparam int    TIMEOUT_CYCLES = 3000;
    localparam int    TIMER_COUNT    = 5;
    localparam word_t SEED           = 32'hfbbc_17c2;
    localparam word_t HALT_ADDR      = 32'h1a11_0000;
    localparam word_t DBG_SIZE       = 32'd16384;
    localparam word_t DBG_RAM_BASE   = 32'd49152;

    logic        clk_i;
    logic        rst_ni;
    word_t       dm_halt_addr_i;
    logic        instr_req_i;
    word_t       instr_addr_i;
    instr_line_t instr_rdata_o;
    logic        instr_rvalid_o;
    logic        instr_gnt_o;
    logic        data_req_i;
    word_t       data_addr_i;
    logic        data_we_i;
    be_t         data_be_i;
    word_t       data_wdata_i;
    word_t       data_rdata_o;
    logic        data_rvalid_o;
    logic        data_gnt_o;
    irq_id_t     irq_id_i;
    logic        irq_ack_i;
    irq_vec_t    irq_o;
    logic        debug_req_o;
    logic        tests_passed_o;
    logic        tests_failed_o;
    logic        exit_valid_o;
    word_t       exit_value_o;

    // reference copy of the RAM bytes
    logic [7:0] ref_mem [2 ** RAM_ADDR_WIDTH];

    int    errors = 0;
    int    cycles = 0;
    word_t rng;

    mm_ram dut0 (.*);

    bind mm_ram mm_ram_properties props0 (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .data_req_i     (data_req_i),
        .data_we_i      (data_we_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .irq_o          (irq_o),
        .debug_req_o    (debug_req_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk_i = ~clk_i;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic word_t xorshift(word_t x);
        word_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    // debug window maps onto byte 49152 and up
    // other addresses keep their low bits
    function automatic ram_addr_t ram_index(word_t addr);
        if ((addr >= HALT_ADDR) && ((addr - HALT_ADDR) < DBG_SIZE)) begin
            return ram_addr_t'(addr - HALT_ADDR + DBG_RAM_BASE);
        end
        return ram_addr_t'(addr);
    endfunction

    task automatic model_write(word_t addr, be_t be, word_t wdata);
        ram_addr_t base;
        base = ram_index(addr) & 16'hfffc;
        for (int k = 0; k < 4; k++) begin
            if (be[k]) begin
                ref_mem[base + ram_addr_t'(k)] = wdata[8*k +: 8];
            end
        end
    endtask

    function automatic word_t model_word(word_t addr);
        ram_addr_t base;
        word_t     w;
        base = ram_index(addr) & 16'hfffc;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = ref_mem[base + ram_addr_t'(k)];
        end
        return w;
    endfunction

    function automatic instr_line_t model_line(word_t addr);
        ram_addr_t   base;
        instr_line_t line;
        base = ram_index(addr) & 16'hfff0;
        for (int k = 0; k < 16; k++) begin
            line[8*k +: 8] = ref_mem[base + ram_addr_t'(k)];
        end
        return line;
    endfunction

    task automatic expect_value(string what, logic [127:0] got, logic [127:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic tick();
        @(posedge clk_i);
        #(DRIVE_DELAY);
    endtask

    task automatic drive_data(word_t addr, logic we, be_t be, word_t wdata);
        data_req_i   = 1'b1;
        data_addr_i  = addr;
        data_we_i    = we;
        data_be_i    = be;
        data_wdata_i = wdata;
    endtask

    task automatic release_data();
        data_req_i = 1'b0;
        data_we_i  = 1'b0;
    endtask

    task automatic data_access(input word_t addr, input logic we, input be_t be,
                               input word_t wdata, output word_t rdata);
        drive_data(addr, we, be, wdata);
        tick();
        release_data();
        expect_value("data_rvalid_o", data_rvalid_o, 1'b1);
        rdata = data_rdata_o;
    endtask

    task automatic fetch_line(input word_t addr, output instr_line_t line);
        instr_req_i  = 1'b1;
        instr_addr_i = addr;
        tick();
        instr_req_i = 1'b0;
        expect_value("instr_rvalid_o", instr_rvalid_o, 1'b1);
        line = instr_rdata_o;
    endtask

    task automatic status_write(word_t addr, word_t wdata, logic exp_pass,
                                logic exp_fail, logic exp_exit);
        drive_data(addr, 1'b1, 4'hf, wdata);
        // sample mid-cycle once the combinational decode has settled
        #5;
        expect_value("tests_passed_o", tests_passed_o, exp_pass);
        expect_value("tests_failed_o", tests_failed_o, exp_fail);
        expect_value("exit_valid_o", exit_valid_o, exp_exit);
        expect_value("exit_value_o", exit_value_o, exp_exit ? wdata : 32'h0);
        tick();
        // we stays high here so only the dropped request clears the status
        data_req_i = 1'b0;
        #5;
        expect_value("status after write", {tests_passed_o, tests_failed_o, exit_valid_o}, 3'b0);
        tick();
        release_data();
    endtask

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        word_t       addr;
        word_t       wdata;
        word_t       rdata;
        word_t       base;
        word_t       mask;
        be_t         be;
        instr_line_t line;

        rng            = SEED;
        rst_ni         = 1'b1;
        dm_halt_addr_i = HALT_ADDR;
        instr_req_i    = 1'b0;
        instr_addr_i   = '0;
        data_req_i     = 1'b0;
        data_addr_i    = '0;
        data_we_i      = 1'b0;
        data_be_i      = '0;
        data_wdata_i   = '0;
        irq_id_i       = '0;
        irq_ack_i      = 1'b0;
        #(DRIVE_DELAY);
        rst_ni = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #(DRIVE_DELAY);
        rst_ni = 1'b1;
        tick();

        // random RAM traffic with a full word first so masked bytes are known
        for (int n = 0; n < 64; n++) begin
            addr  = next_rand() & 32'h0000_ffff;
            wdata = next_rand();
            data_access(addr, 1'b1, 4'hf, wdata, rdata);
            model_write(addr, 4'hf, wdata);
            wdata = next_rand();
            be    = be_t'(next_rand());
            data_access(addr, 1'b1, be, wdata, rdata);
            model_write(addr, be, wdata);
            data_access(addr, 1'b0, 4'h0, 32'h0, rdata);
            expect_value("ram read", rdata, model_word(addr));
        end

        // one full line written through the debug window
        base = HALT_ADDR + (next_rand() & 32'h0000_3ff0);
        for (int n = 0; n < 4; n++) begin
            wdata = next_rand();
            data_access(base + word_t'(4 * n), 1'b1, 4'hf, wdata, rdata);
            model_write(base + word_t'(4 * n), 4'hf, wdata);
        end
        for (int n = 0; n < 4; n++) begin
            addr = DBG_RAM_BASE + (base - HALT_ADDR) + word_t'(4 * n);
            data_access(addr, 1'b0, 4'h0, 32'h0, rdata);
            expect_value("debug alias read", rdata, model_word(addr));
        end
        fetch_line(base + (next_rand() & 32'h0000_000c), line);
        expect_value("debug alias fetch", line, model_line(base));

        status_write(ADDR_TEST_STATUS, TEST_PASS_CODE, 1'b1, 1'b0, 1'b0);
        status_write(ADDR_TEST_STATUS, TEST_FAIL_CODE, 1'b0, 1'b1, 1'b0);
        status_write(ADDR_TEST_STATUS, 32'd42, 1'b0, 1'b0, 1'b0);
        status_write(ADDR_EXIT, next_rand(), 1'b0, 1'b0, 1'b1);

        // a read of the status register raises nothing
        drive_data(ADDR_TEST_STATUS, 1'b0, 4'hf, TEST_PASS_CODE);
        #5;
        expect_value("status on read", {tests_passed_o, tests_failed_o, exit_valid_o}, 3'b0);
        tick();
        release_data();

        data_access(32'h0001_0000, 1'b0, 4'hf, 32'h0, rdata);
        expect_value("read outside RAM", rdata, 32'h0);

        // ----------------------------------------
        // timer
        // ----------------------------------------
        mask = next_rand() | 32'h0000_0101;
        data_access(ADDR_TIMER_MASK, 1'b1, 4'hf, mask, rdata);
        drive_data(ADDR_TIMER_COUNT, 1'b1, 4'hf, word_t'(TIMER_COUNT));
        tick();
        release_data();
        for (int i = 1; i <= TIMER_COUNT; i++) begin
            tick();
            expect_value("irq_o countdown", irq_o, (i == TIMER_COUNT) ? mask : 32'h0);
        end
        irq_ack_i = 1'b1;
        irq_id_i  = irq_id_t'(8);
        tick();
        irq_ack_i = 1'b0;
        expect_value("irq_o after ack", irq_o, mask & ~32'h0000_0100);

        // ----------------------------------------
        // debug request
        // ----------------------------------------
        drive_data(ADDR_DEBUG_CTRL, 1'b1, 4'hf, 32'h8000_0007);
        tick();
        release_data();
        for (int i = 1; i <= 8; i++) begin
            tick();
            expect_value("debug_req_o level", debug_req_o, i >= 7);
        end
        drive_data(ADDR_DEBUG_CTRL, 1'b1, 4'hf, 32'h0000_0001);
        tick();
        release_data();
        tick();
        expect_value("debug_req_o restored", debug_req_o, 1'b0);

        // pulse of 4 after a delay of 3 with a second write that must be dropped
        drive_data(ADDR_DEBUG_CTRL, 1'b1, 4'hf, 32'hc004_0003);
        tick();
        release_data();
        for (int i = 1; i <= 12; i++) begin
            tick();
            if (i == 4) begin
                drive_data(ADDR_DEBUG_CTRL, 1'b1, 4'hf, 32'h8000_0005);
            end
            if (i == 5) begin
                release_data();
            end
            expect_value("debug_req_o pulse", debug_req_o, (i >= 3) && (i <= 6));
        end

        tick();
        tick();
        $display("check errors: %0d, assertion failures: %0d", errors, dut0.props0.fail_cnt);
        if ((errors == 0) && (dut0.props0.fail_cnt == 0)) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
common/mm_pkg.sv
common/ram_port_if.sv
common/periph_wr_if.sv
rtl/mem_addr_map.sv
rtl/data_decoder.sv
ram/dp_ram.sv
rtl/irq_timer.sv
rtl/debug_req_ctrl.sv
rtl/mm_ram.sv
dv/mm_ram_properties.sv
dv/tb_mm_ram.sv
